//--- decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Instruction word as delivered by fetch
`define DEC_INSTR_W     32
// Architectural register value
`define DEC_DATA_W      32
// Number of architectural registers
`define DEC_NUM_REGS    32
// Reorder-buffer ticket, 16 entries in flight
`define DEC_ROB_W       4
`define DEC_PC_W        32
`define DEC_OPC_W       7
// Immediate of ADDI and the memory ops
`define DEC_OFFSET_W    15

//////////////////////////////
// Instruction fields
//////////////////////////////

`define DEC_OPC_RANGE   31:25
`define DEC_RD_RANGE    24:20
`define DEC_RA_RANGE    19:15
// rb and offset overlap, the opcode tells which one is meant
`define DEC_RB_RANGE    14:10
`define DEC_OFF_RANGE   14:0

// Supported opcodes, every other value decodes as illegal
`define DEC_OP_ADD      7'h00
`define DEC_OP_SUB      7'h01
`define DEC_OP_MUL      7'h02
`define DEC_OP_ADDI     7'h03
`define DEC_OP_LDW      7'h11
`define DEC_OP_STW      7'h13
`define DEC_OP_NOP      7'h7f

`endif

//--- decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

    // Register index, sized from the register count
    typedef logic [$clog2(`DEC_NUM_REGS)-1:0] reg_addr_t;
    // Register value
    typedef logic [`DEC_DATA_W-1:0]           reg_data_t;
    // Reorder-buffer ticket, also used as instruction id
    typedef logic [`DEC_ROB_W-1:0]            rob_id_t;
    typedef logic [`DEC_OPC_W-1:0]            opcode_t;

    // Request towards the ALU pipe
    // Also carries illegal instructions so the ROB can retire them
    typedef struct packed {
        opcode_t                   opcode;
        reg_addr_t                 rd;
        reg_data_t                 ra_data;
        reg_data_t                 rb_data;
        logic [`DEC_OFFSET_W-1:0]  offset;
        rob_id_t                   ticket_src1;
        logic                      blocks_src1;
        rob_id_t                   ticket_src2;
        logic                      blocks_src2;
        logic                      illegal;
        rob_id_t                   id;
        logic [`DEC_PC_W-1:0]      pc;
    } alu_req_t;

    // Request towards the MUL pipe
    // Only one operation, so no opcode, offset or illegal flag
    typedef struct packed {
        reg_addr_t                 rd;
        reg_data_t                 ra_data;
        reg_data_t                 rb_data;
        rob_id_t                   ticket_src1;
        logic                      blocks_src1;
        rob_id_t                   ticket_src2;
        logic                      blocks_src2;
        rob_id_t                   id;
        logic [`DEC_PC_W-1:0]      pc;
    } mul_req_t;

endpackage

//--- decode_ifs.sv
`include "decode_cfg.svh"

//////////////////////////////
// Write-back port
//////////////////////////////

// One result per cycle from the execute stages, no handshake
interface wb_if;
    import decode_pkg::*;

    logic       en;
    reg_addr_t  dest;
    reg_data_t  data;
    rob_id_t    id;

    modport sink (input en, dest, data, id);
endinterface

//////////////////////////////
// Decoded instruction
//////////////////////////////

interface dec_if;
    import decode_pkg::*;

    opcode_t                   opcode;
    reg_addr_t                 rd;
    reg_addr_t                 ra;
    // Second read address, rd for stores
    reg_addr_t                 rs2;
    logic                      uses_src1;
    logic                      uses_src2;
    logic                      writes_rd;
    logic [`DEC_OFFSET_W-1:0]  offset;
    logic                      illegal;
    // Instruction leaves fetch this cycle
    logic                      accept;
    logic                      route_alu;
    logic                      route_mul;

    modport source (output opcode, rd, ra, rs2, uses_src1, uses_src2, writes_rd,
                    offset, illegal, accept, route_alu, route_mul);
    modport sink   (input opcode, rd, ra, rs2, uses_src1, uses_src2, writes_rd,
                    offset, illegal, accept, route_alu, route_mul);
endinterface

//--- instr_decoder.sv
`include "decode_cfg.svh"

module instr_decoder
(
    input  logic [`DEC_INSTR_W-1:0]  instr,
    input  logic                     fetch_valid,
    input  logic                     stall,
    dec_if.source                    dec
);
    import decode_pkg::*;

    opcode_t  opc;
    logic     is_mul;

    assign opc    = instr[`DEC_OPC_RANGE];
    assign is_mul = (opc == `DEC_OP_MUL);

    //////////////////////////////
    // Field extraction
    //////////////////////////////

    assign dec.opcode = opc;
    assign dec.rd     = instr[`DEC_RD_RANGE];
    assign dec.ra     = instr[`DEC_RA_RANGE];
    assign dec.offset = instr[`DEC_OFF_RANGE];
    // Stores read the data register through the second port
    assign dec.rs2    = (opc == `DEC_OP_STW) ? instr[`DEC_RD_RANGE] : instr[`DEC_RB_RANGE];

    //////////////////////////////
    // Opcode classification
    //////////////////////////////

    always_comb
    begin
        // Default is a NOP, nothing read and nothing written
        dec.uses_src1 = 1'b0;
        dec.uses_src2 = 1'b0;
        dec.writes_rd = 1'b0;
        dec.illegal   = 1'b0;
        case (opc)
            `DEC_OP_ADD, `DEC_OP_SUB, `DEC_OP_MUL:
            begin
                dec.uses_src1 = 1'b1;
                dec.uses_src2 = 1'b1;
                dec.writes_rd = 1'b1;
            end
            // Base register plus immediate
            `DEC_OP_LDW, `DEC_OP_ADDI:
            begin
                dec.uses_src1 = 1'b1;
                dec.writes_rd = 1'b1;
            end
            // Address from ra, data from rd
            `DEC_OP_STW:
            begin
                dec.uses_src1 = 1'b1;
                dec.uses_src2 = 1'b1;
            end
            `DEC_OP_NOP:
            begin
                dec.illegal = 1'b0;
            end
            default:
            begin
                dec.illegal = 1'b1;
            end
        endcase
    end

    // Accept and route, illegal ops travel the ALU path
    assign dec.accept    = fetch_valid & ~stall;
    assign dec.route_mul = dec.accept & is_mul;
    assign dec.route_alu = dec.accept & ~is_mul;

endmodule

//--- reg_file.sv
`include "decode_cfg.svh"

module reg_file
(
    input  logic                  clock,
    input  logic                  rst_n,
    dec_if.sink                   dec,
    wb_if.sink                    wb,
    output decode_pkg::reg_data_t ra_data,
    output decode_pkg::reg_data_t rb_data
);
    import decode_pkg::*;

    reg_data_t  regs [`DEC_NUM_REGS];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `DEC_NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.en)
        begin
            regs[wb.dest] <= wb.data;
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    // A write-back in the same cycle is forwarded ahead of the array
    assign ra_data = (wb.en && (wb.dest == dec.ra))  ? wb.data : regs[dec.ra];
    // Second port already carries rd for stores
    assign rb_data = (wb.en && (wb.dest == dec.rs2)) ? wb.data : regs[dec.rs2];

endmodule

//--- scoreboard.sv
`include "decode_cfg.svh"

module scoreboard
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 flush_rob,
    dec_if.sink                  dec,
    wb_if.sink                   wb,
    output decode_pkg::rob_id_t  tail,
    output decode_pkg::rob_id_t  ticket_src1,
    output decode_pkg::rob_id_t  ticket_src2,
    output logic                 blocks_src1,
    output logic                 blocks_src2
);
    import decode_pkg::*;

    // One bit per register, set while a producer is in flight
    logic [`DEC_NUM_REGS-1:0]  blocked;
    // Ticket of the youngest producer of each register
    rob_id_t                   tickets [`DEC_NUM_REGS];
    rob_id_t                   tail_q;
    logic                      set_rd;
    logic                      wb_hit;

    // New producer enters the window
    assign set_rd = dec.accept & dec.writes_rd;
    // Result of the youngest producer comes back
    assign wb_hit = wb.en & (tickets[wb.dest] == wb.id);

    //////////////////////////////
    // Source lookup
    //////////////////////////////

    assign ticket_src1 = tickets[dec.ra];
    assign ticket_src2 = tickets[dec.rs2];

    // A matching write-back this cycle means the value is already on the bypass
    assign blocks_src1 = dec.uses_src1 & blocked[dec.ra]
                       & ~(wb.en & (wb.id == tickets[dec.ra]));
    assign blocks_src2 = dec.uses_src2 & blocked[dec.rs2]
                       & ~(wb.en & (wb.id == tickets[dec.rs2]));

    //////////////////////////////
    // Blocked bits and tail
    //////////////////////////////

    always_ff @(posedge clock)
    begin
        if (!rst_n || flush_rob)
        begin
            blocked <= '0;
            tail_q  <= '0;
        end
        else
        begin
            if (wb_hit)
            begin
                blocked[wb.dest] <= 1'b0;
            end
            // Written after the clear so a new producer wins
            if (set_rd)
            begin
                blocked[dec.rd] <= 1'b1;
            end
            if (dec.accept)
            begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // Tickets only matter while blocked, flush_rob leaves them alone
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `DEC_NUM_REGS; i++)
            begin
                tickets[i] <= '0;
            end
        end
        else if (set_rd)
        begin
            tickets[dec.rd] <= tail_q;
        end
    end

    assign tail = tail_q;

endmodule

//--- issue_reg.sv
`include "decode_cfg.svh"

module issue_reg
#(
    parameter type payload_t = logic
)
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      load,
    input  payload_t  payload_in,
    output logic      valid,
    output payload_t  payload
);

    logic      valid_q;
    payload_t  payload_q;

    // Valid follows load every cycle, a flush kills it
    always_ff @(posedge clock)
    begin
        if (!rst_n || flush)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= load;
        end
    end

    // Payload only moves with a new request
    always_ff @(posedge clock)
    begin
        if (load)
        begin
            payload_q <= payload_in;
        end
    end

    // Request in flight is dropped as soon as flush is seen
    assign valid   = valid_q & ~flush;
    assign payload = payload_q;

endmodule

//--- decode_top.sv
`include "decode_cfg.svh"

module decode_top
(
    input  logic                     clock,
    input  logic                     rst_n,
    // Pipeline control
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     flush_rob,
    // From fetch
    input  logic                     fetch_valid,
    input  logic [`DEC_INSTR_W-1:0]  fetch_instr,
    input  logic [`DEC_PC_W-1:0]     fetch_pc,
    // Write-back from execute
    input  logic                     wb_en,
    input  decode_pkg::reg_addr_t    wb_dest,
    input  decode_pkg::reg_data_t    wb_data,
    input  decode_pkg::rob_id_t      wb_id,
    // Issue side
    output logic                     alu_valid,
    output decode_pkg::alu_req_t     alu_req,
    output logic                     mul_valid,
    output decode_pkg::mul_req_t     mul_req
);
    import decode_pkg::*;

    wb_if       wb ();
    dec_if      dec ();
    reg_data_t  ra_data;
    reg_data_t  rb_data;
    rob_id_t    tail;
    rob_id_t    ticket_src1;
    rob_id_t    ticket_src2;
    logic       blocks_src1;
    logic       blocks_src2;
    alu_req_t   alu_next;
    mul_req_t   mul_next;

    assign wb.en   = wb_en;
    assign wb.dest = wb_dest;
    assign wb.data = wb_data;
    assign wb.id   = wb_id;

    //////////////////////////////
    // Decode and operand stage
    //////////////////////////////

    instr_decoder u_decoder (.instr(fetch_instr), .fetch_valid(fetch_valid), .stall(stall),
                             .dec(dec));

    reg_file u_reg_file (.clock(clock), .rst_n(rst_n), .dec(dec), .wb(wb),
                         .ra_data(ra_data), .rb_data(rb_data));

    scoreboard u_scoreboard (.clock(clock), .rst_n(rst_n), .flush_rob(flush_rob),
                             .dec(dec), .wb(wb), .tail(tail),
                             .ticket_src1(ticket_src1), .ticket_src2(ticket_src2),
                             .blocks_src1(blocks_src1), .blocks_src2(blocks_src2));

    //////////////////////////////
    // Request assembly
    //////////////////////////////

    // Id is the tail before this instruction bumps it
    assign alu_next = '{opcode: dec.opcode, rd: dec.rd, ra_data: ra_data, rb_data: rb_data,
                        offset: dec.offset, ticket_src1: ticket_src1,
                        blocks_src1: blocks_src1, ticket_src2: ticket_src2,
                        blocks_src2: blocks_src2, illegal: dec.illegal, id: tail,
                        pc: fetch_pc};
    assign mul_next = '{rd: dec.rd, ra_data: ra_data, rb_data: rb_data,
                        ticket_src1: ticket_src1, blocks_src1: blocks_src1,
                        ticket_src2: ticket_src2, blocks_src2: blocks_src2, id: tail,
                        pc: fetch_pc};

    // One cycle to the execute pipes
    issue_reg #(.payload_t(alu_req_t)) alu_issue (.clock(clock), .rst_n(rst_n), .flush(flush),
        .load(dec.route_alu), .payload_in(alu_next), .valid(alu_valid), .payload(alu_req));

    issue_reg #(.payload_t(mul_req_t)) mul_issue (.clock(clock), .rst_n(rst_n), .flush(flush),
        .load(dec.route_mul), .payload_in(mul_next), .valid(mul_valid), .payload(mul_req));

endmodule

//--- decode_chk.sv
`include "decode_cfg.svh"

module decode_chk
(
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     flush_rob,
    input  logic                     fetch_valid,
    input  logic [`DEC_INSTR_W-1:0]  fetch_instr,
    input  logic [`DEC_PC_W-1:0]     fetch_pc,
    input  logic                     wb_en,
    input  decode_pkg::reg_addr_t    wb_dest,
    input  decode_pkg::reg_data_t    wb_data,
    input  decode_pkg::rob_id_t      wb_id,
    input  logic                     alu_valid,
    input  decode_pkg::alu_req_t     alu_req,
    input  logic                     mul_valid,
    input  decode_pkg::mul_req_t     mul_req
);
    import decode_pkg::*;

    int                        fail_count = 0;
    // Shadow of the architectural state, fed from the top-level ports
    reg_data_t                 sh_regs [`DEC_NUM_REGS];
    logic [`DEC_NUM_REGS-1:0]  sh_blocked;
    rob_id_t                   sh_ticket [`DEC_NUM_REGS];
    rob_id_t                   sh_tail;
    // Presented instruction
    opcode_t                   opc;
    reg_addr_t                 ra;
    reg_addr_t                 rs2;
    reg_addr_t                 rd;
    logic                      is_rr;
    logic                      is_ri;
    logic                      is_st;
    logic                      legal;
    logic                      accept;
    alu_req_t                  nxt_alu;
    // Request expected one cycle after accept
    alu_req_t                  exp_alu;
    mul_req_t                  exp_mul;
    alu_req_t                  alu_seen;
    mul_req_t                  mul_seen;
    logic                      exp_alu_v;
    logic                      exp_mul_v;
    logic                      tk1_chk;
    logic                      tk2_chk;
    logic                      stall_q;
    logic                      after_reset;

    //////////////////////////////
    // Reference decode
    //////////////////////////////

    assign opc    = fetch_instr[`DEC_OPC_RANGE];
    assign rd     = fetch_instr[`DEC_RD_RANGE];
    assign ra     = fetch_instr[`DEC_RA_RANGE];
    // Two-source ops, then register plus immediate, then the store
    assign is_rr  = opc inside {`DEC_OP_ADD, `DEC_OP_SUB, `DEC_OP_MUL};
    assign is_ri  = opc inside {`DEC_OP_LDW, `DEC_OP_ADDI};
    assign is_st  = (opc == `DEC_OP_STW);
    assign legal  = is_rr | is_ri | is_st | (opc == `DEC_OP_NOP);
    // Store data comes from rd
    assign rs2    = is_st ? rd : fetch_instr[`DEC_RB_RANGE];
    assign accept = fetch_valid & ~stall;

    always_comb
    begin
        nxt_alu             = '0;
        nxt_alu.opcode      = opc;
        nxt_alu.rd          = rd;
        // Same-cycle write-back wins over the stored value
        nxt_alu.ra_data     = (wb_en && wb_dest == ra) ? wb_data : sh_regs[ra];
        nxt_alu.rb_data     = (wb_en && wb_dest == rs2) ? wb_data : sh_regs[rs2];
        nxt_alu.offset      = fetch_instr[`DEC_OFF_RANGE];
        nxt_alu.blocks_src1 = (is_rr | is_ri | is_st) & sh_blocked[ra]
                              & ~(wb_en & (wb_id == sh_ticket[ra]));
        nxt_alu.blocks_src2 = (is_rr | is_st) & sh_blocked[rs2]
                              & ~(wb_en & (wb_id == sh_ticket[rs2]));
        // Ticket of an idle register carries no meaning
        if (sh_blocked[ra])
            nxt_alu.ticket_src1 = sh_ticket[ra];
        if (sh_blocked[rs2])
            nxt_alu.ticket_src2 = sh_ticket[rs2];
        nxt_alu.illegal     = ~legal;
        nxt_alu.id          = sh_tail;
        nxt_alu.pc          = fetch_pc;
    end

    //////////////////////////////
    // Shadow state
    //////////////////////////////

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `DEC_NUM_REGS; i++)
            begin
                sh_regs[i] <= '0;
            end
        end
        else if (wb_en)
            sh_regs[wb_dest] <= wb_data;
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n || flush_rob)
        begin
            sh_blocked <= '0;
            sh_tail    <= '0;
        end
        else
        begin
            if (wb_en && sh_ticket[wb_dest] == wb_id)
                sh_blocked[wb_dest] <= 1'b0;
            // Later write, so a new producer of the same register wins
            if (accept && (is_rr || is_ri))
            begin
                sh_blocked[rd] <= 1'b1;
                sh_ticket[rd]  <= sh_tail;
            end
            if (accept)
                sh_tail <= sh_tail + rob_id_t'(1);
        end
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            exp_alu_v <= 1'b0;
            exp_mul_v <= 1'b0;
            stall_q   <= 1'b0;
        end
        else
        begin
            // A flush in the accept cycle kills the request
            exp_alu_v <= accept & ~is_mul_op() & ~flush;
            exp_mul_v <= accept & is_mul_op() & ~flush;
            stall_q   <= stall;
        end
        after_reset <= ~rst_n;
        if (accept)
        begin
            exp_alu <= nxt_alu;
            tk1_chk <= sh_blocked[ra];
            tk2_chk <= sh_blocked[rs2];
        end
    end

    function automatic logic is_mul_op();
        return opc == `DEC_OP_MUL;
    endfunction

    assign exp_mul = '{rd: exp_alu.rd, ra_data: exp_alu.ra_data, rb_data: exp_alu.rb_data,
                       ticket_src1: exp_alu.ticket_src1, blocks_src1: exp_alu.blocks_src1,
                       ticket_src2: exp_alu.ticket_src2, blocks_src2: exp_alu.blocks_src2,
                       id: exp_alu.id, pc: exp_alu.pc};

    // Hide tickets of registers that were idle at decode
    always_comb
    begin
        alu_seen = alu_req;
        mul_seen = mul_req;
        if (!tk1_chk)
        begin
            alu_seen.ticket_src1 = '0;
            mul_seen.ticket_src1 = '0;
        end
        if (!tk2_chk)
        begin
            alu_seen.ticket_src2 = '0;
            mul_seen.ticket_src2 = '0;
        end
    end

    //////////////////////////////
    // Assertions
    //////////////////////////////

    alu_valid_ok: assert property (@(posedge clock) disable iff (!rst_n)
        alu_valid == (exp_alu_v && !flush))
    else
    begin
        fail_count++;
        $error("Error at %0t: alu_valid is %b, expected %b", $time, $sampled(alu_valid),
               $sampled(exp_alu_v && !flush));
    end

    mul_valid_ok: assert property (@(posedge clock) disable iff (!rst_n)
        mul_valid == (exp_mul_v && !flush))
    else
    begin
        fail_count++;
        $error("Error at %0t: mul_valid is %b, expected %b", $time, $sampled(mul_valid),
               $sampled(exp_mul_v && !flush));
    end

    // Covers opcode, pc, id, operands, tickets, blocks and the illegal flag
    alu_req_ok: assert property (@(posedge clock) disable iff (!rst_n)
        alu_valid |-> alu_seen == exp_alu)
    else
    begin
        fail_count++;
        $error("Error at %0t: alu_req is %h, expected %h", $time, $sampled(alu_seen),
               $sampled(exp_alu));
    end

    mul_req_ok: assert property (@(posedge clock) disable iff (!rst_n)
        mul_valid |-> mul_seen == exp_mul)
    else
    begin
        fail_count++;
        $error("Error at %0t: mul_req is %h, expected %h", $time, $sampled(mul_seen),
               $sampled(exp_mul));
    end

    // Flush, a stall one cycle back, or the first cycle out of reset
    quiet_ok: assert property (@(posedge clock) disable iff (!rst_n)
        (flush || stall_q || after_reset) |-> !(alu_valid || mul_valid))
    else
    begin
        fail_count++;
        $error("Request valid raised at %0t during a flush, after a stall or after reset",
               $time);
    end

endmodule

// Checker rides along inside every decode_top
bind decode_top decode_chk chk0 (.clock(clock), .rst_n(rst_n), .stall(stall), .flush(flush),
    .flush_rob(flush_rob), .fetch_valid(fetch_valid), .fetch_instr(fetch_instr),
    .fetch_pc(fetch_pc), .wb_en(wb_en), .wb_dest(wb_dest), .wb_data(wb_data), .wb_id(wb_id),
    .alu_valid(alu_valid), .alu_req(alu_req), .mul_valid(mul_valid), .mul_req(mul_req));

//--- decode_tb.sv
`include "decode_cfg.svh"

module decode_tb;
    import decode_pkg::*;

    localparam int STIM_CYCLES = 1500;
    // Reset, stimulus and drain with plenty of margin
    localparam int MAX_CYCLES  = STIM_CYCLES + 500;

    typedef struct packed {
        reg_addr_t  dest;
        rob_id_t    id;
    } wb_entry_t;

    logic                     clock;
    logic                     rst_n;
    logic                     stall;
    logic                     flush;
    logic                     flush_rob;
    logic                     fetch_valid;
    logic [`DEC_INSTR_W-1:0]  fetch_instr;
    logic [`DEC_PC_W-1:0]     fetch_pc;
    logic                     wb_en;
    reg_addr_t                wb_dest;
    reg_data_t                wb_data;
    rob_id_t                  wb_id;
    logic                     alu_valid;
    alu_req_t                 alu_req;
    logic                     mul_valid;
    mul_req_t                 mul_req;
    int                       cycle_count = 0;
    int                       alu_count = 0;
    int                       mul_count = 0;
    // Dispatched producers still owing a write-back
    wb_entry_t                pending [$];

    decode_top dut0 (.clock(clock), .rst_n(rst_n), .stall(stall), .flush(flush),
        .flush_rob(flush_rob), .fetch_valid(fetch_valid), .fetch_instr(fetch_instr),
        .fetch_pc(fetch_pc), .wb_en(wb_en), .wb_dest(wb_dest), .wb_data(wb_data),
        .wb_id(wb_id), .alu_valid(alu_valid), .alu_req(alu_req), .mul_valid(mul_valid),
        .mul_req(mul_req));

    initial clock = 1'b0;
    always #2 clock = ~clock;

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    function automatic logic [`DEC_INSTR_W-1:0] random_instr();
        logic [`DEC_INSTR_W-1:0] word;
        word = $urandom;
        case ($urandom_range(9))
            0: word[`DEC_OPC_RANGE] = `DEC_OP_ADD;
            1: word[`DEC_OPC_RANGE] = `DEC_OP_SUB;
            2, 3: word[`DEC_OPC_RANGE] = `DEC_OP_MUL;
            4: word[`DEC_OPC_RANGE] = `DEC_OP_ADDI;
            5: word[`DEC_OPC_RANGE] = `DEC_OP_LDW;
            6: word[`DEC_OPC_RANGE] = `DEC_OP_STW;
            7: word[`DEC_OPC_RANGE] = `DEC_OP_NOP;
            // Random opcode, nearly always illegal
            default: word[`DEC_OPC_RANGE] = word[`DEC_OPC_RANGE];
        endcase
        // r0..r7 only, so dependencies and bypasses show up often
        word[24:23] = 2'b00;
        word[19:18] = 2'b00;
        word[14:13] = 2'b00;
        return word;
    endfunction

    task automatic collect_writers();
        wb_entry_t entry;
        if (alu_valid)
        begin
            alu_count++;
            if (alu_req.opcode inside {`DEC_OP_ADD, `DEC_OP_SUB, `DEC_OP_ADDI, `DEC_OP_LDW})
            begin
                entry.dest = alu_req.rd;
                entry.id   = alu_req.id;
                pending.push_back(entry);
            end
        end
        if (mul_valid)
        begin
            mul_count++;
            entry.dest = mul_req.rd;
            entry.id   = mul_req.id;
            pending.push_back(entry);
        end
    endtask

    task automatic drive_writeback();
        int unsigned idx;
        wb_en   = 1'b0;
        wb_data = $urandom;
        if (pending.size() > 0 && $urandom_range(99) < 60)
        begin
            // Results come back out of order
            idx     = $urandom_range(pending.size() - 1);
            wb_en   = 1'b1;
            wb_dest = pending[idx].dest;
            wb_id   = pending[idx].id;
            pending.delete(idx);
        end
        else if ($urandom_range(99) < 10)
        begin
            wb_en   = 1'b1;
            wb_dest = reg_addr_t'($urandom_range(7));
            wb_id   = rob_id_t'($urandom);
        end
    endtask

    task automatic drive_cycle();
        logic held;
        // Fetch keeps a stalled instruction in place
        held      = fetch_valid && stall;
        stall     = ($urandom_range(99) < 15);
        flush     = ($urandom_range(99) < 5);
        flush_rob = ($urandom_range(99) < 2);
        if (!held)
        begin
            fetch_valid = ($urandom_range(99) < 80);
            fetch_instr = random_instr();
            fetch_pc    = fetch_pc + 4;
        end
        drive_writeback();
        if (flush_rob)
            pending.delete();
    endtask

    task automatic report_result();
        int fails;
        int misses;
        fails  = dut0.chk0.fail_count;
        misses = 0;
        if (alu_count == 0)
        begin
            $display("No ALU request was issued during the run");
            misses++;
        end
        if (mul_count == 0)
        begin
            $display("No MUL request was issued during the run");
            misses++;
        end
        $display("Assertion failures: %0d, coverage misses: %0d, ALU requests: %0d, MUL: %0d",
                 fails, misses, alu_count, mul_count);
        if (fails + misses == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        void'($urandom(69207));
        rst_n       = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        flush_rob   = 1'b0;
        // An instruction already waits in fetch while reset is held
        fetch_valid = 1'b1;
        fetch_instr = random_instr();
        fetch_pc    = '0;
        wb_en       = 1'b0;
        wb_dest     = '0;
        wb_data     = '0;
        wb_id       = '0;
        repeat (8) @(negedge clock);
        rst_n = 1'b1;
        for (int i = 0; i < STIM_CYCLES; i++)
        begin
            @(negedge clock);
            collect_writers();
            drive_cycle();
        end
        @(negedge clock);
        // Quiet inputs and let the last request drain
        fetch_valid = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        flush_rob   = 1'b0;
        wb_en       = 1'b0;
        repeat (4) @(negedge clock);
        report_result();
        $finish;
    end

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

//--- all.f
+incdir+.
decode_pkg.sv
decode_ifs.sv
instr_decoder.sv
reg_file.sv
scoreboard.sv
issue_reg.sv
decode_top.sv
decode_chk.sv
decode_tb.sv

//--- Makefile
VERILATOR   ?= verilator
TOP         ?= decode_tb
FILELIST    ?= all.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 1000
VFLAGS      ?= --assert --timing
PASS_TEXT   ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR) \
		-f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
